//--- build.f
source/modbus_pkg.sv
source/uart_pkg.sv
source/rtu_regs.sv
source/pdu_buffer.sv
source/crc16_engine.sv
source/uart_tx.sv
source/frame_sequencer.sv
source/modbus_rtu_master.sv
sim/modbus_rtu_master_chk.sv
sim/tb_modbus_rtu_master.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Modbus RTU master testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_modbus_rtu_master -f build.f

./obj_dir/Vtb_modbus_rtu_master +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1

//--- sim/modbus_rtu_master_chk.sv
/*
	Line and handshake assertions for the RTU master
	Idle line level, driver enable against ready, and
	ready only dropping after a control write
*/

`timescale 1ns/1ps

module modbus_rtu_master_chk (
	input logic                 clk,
	input logic                 reset,
	input modbus_pkg::cs_addr_t cs_addr,
	input logic                 cs_wr,
	input logic                 ready,
	input logic                 txd,
	input logic                 oe
);
	import modbus_pkg::*;

	int unsigned fail_count = 0;

	idle_line_high: assert property (@(posedge clk) disable iff (reset) !oe |-> txd)
	else begin
		fail_count++;
		$error("txd low while the line driver is off");
	end

	driver_off_when_ready: assert property (@(posedge clk) disable iff (reset) ready |-> !oe)
	else begin
		fail_count++;
		$error("oe high while ready");
	end

	// busy only ever starts from a control write
	ready_falls_on_start: assert property (@(posedge clk) disable iff (reset)
		$fell(ready) |-> $past(cs_wr && cs_addr == REG_CONTROL))
	else begin
		fail_count++;
		$error("ready fell without a control write");
	end

endmodule

bind modbus_rtu_master modbus_rtu_master_chk u_chk (
	.clk     (clk),
	.reset   (reset),
	.cs_addr (cs_addr),
	.cs_wr   (cs_wr),
	.ready   (ready),
	.txd     (txd),
	.oe      (oe)
);

//--- sim/tb_modbus_rtu_master.sv
/*
	Testbench for the Modbus RTU master, transmit side
	Random register, PDU and frame traffic from an xorshift source.
	A line decoder samples txd at mid-bit and compares each byte
	with a frame built from a software CRC-16 model.
*/

`timescale 1ns/1ps

module tb_modbus_rtu_master;
	import modbus_pkg::*;
	import uart_pkg::*;

	localparam int SEL_TXD   = 0;
	localparam int SEL_OE    = 1;
	localparam int SEL_READY = 2;

	logic           clk = 1'b0;
	logic           reset;
	cs_addr_t       cs_addr;
	logic           cs_wr;
	cs_data_t       cs_wrd;
	cs_data_t       cs_rdd;
	pdu_word_addr_t pdu_addr;
	logic           pdu_wr;
	cs_data_t       pdu_wrd;
	cs_data_t       pdu_rdd;
	logic           ready;
	logic           txd;
	logic           oe;

	logic [31:0] rng = 32'hf05b;
	int          cycle_count = 0;
	cs_data_t    pdu_model [64];
	cs_data_t    reg_model [3];  // size, config, slave address
	byte_t       frame_q [$];

	modbus_rtu_master i_dut (
		.clk      (clk),
		.reset    (reset),
		.cs_addr  (cs_addr),
		.cs_wr    (cs_wr),
		.cs_wrd   (cs_wrd),
		.cs_rdd   (cs_rdd),
		.pdu_addr (pdu_addr),
		.pdu_wr   (pdu_wr),
		.pdu_wrd  (pdu_wrd),
		.pdu_rdd  (pdu_rdd),
		.ready    (ready),
		.txd      (txd),
		.oe       (oe)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cycle_count <= cycle_count + 1;

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// bitwise reflected CRC with one input bit per step
	function automatic crc_t crc_add_byte(input crc_t c, input byte_t b);
		crc_t r;
		logic fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[0] ^ b[i];
			r  = r >> 1;
			if (fb)
				r = r ^ CRC_POLY;
		end
		return r;
	endfunction

	function automatic logic line_level(input int which);
		case (which)
			SEL_TXD: return txd;
			SEL_OE:  return oe;
			default: return ready;
		endcase
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("test failed");
		$fatal(1);
	endtask

	always @(negedge clk) begin
		if (i_dut.u_chk.fail_count != 0)
			stop_with_failure("a bound assertion on the line outputs failed");
	end

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
	endtask

	// n counts negedges up to and including the one that saw the level
	task automatic wait_for(input int which, input logic level, input int limit,
	                        input string what, output int n);
		logic done;
		n    = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			n++;
			if (line_level(which) === level)
				done = 1'b1;
			else if (n >= limit)
				stop_with_failure($sformatf("timed out waiting for %s", what));
		end
	endtask

	task automatic skip_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic write_reg(input cs_addr_t a, input cs_data_t d);
		@(posedge clk);
		#2;
		cs_addr = a;
		cs_wrd  = d;
		cs_wr   = 1'b1;
		@(posedge clk);
		#2;
		cs_wr = 1'b0;
	endtask

	task automatic read_reg(input cs_addr_t a, output cs_data_t d);
		@(posedge clk);
		#2;
		cs_addr = a;
		@(negedge clk);
		d = cs_rdd;
	endtask

	task automatic write_pdu(input pdu_word_addr_t a, input cs_data_t d);
		@(posedge clk);
		#2;
		pdu_addr = a;
		pdu_wrd  = d;
		pdu_wr   = 1'b1;
		@(posedge clk);
		#2;
		pdu_wr = 1'b0;
	endtask

	task automatic read_pdu(input pdu_word_addr_t a, output cs_data_t d);
		@(posedge clk);
		#2;
		pdu_addr = a;
		@(negedge clk);
		d = pdu_rdd;
	endtask

	task automatic check_registers();
		cs_data_t d;
		for (int i = 0; i < 3; i++) begin
			read_reg(cs_addr_t'(i), d);
			check_value($sformatf("cs_rdd[%0d]", i), d, reg_model[i]);
		end
		read_reg(REG_CONTROL, d);
		check_value("cs_rdd status", d, 32'd1);
	endtask

	task automatic register_test();
		cs_data_t v;
		int       sel;
		for (int i = 0; i < 40; i++) begin
			sel = int'(next_random() % 3);
			v   = next_random();
			if (!v[31])
				v = v & 32'h1ff;  // mostly near the legal limits
			write_reg(cs_addr_t'(sel), v);
			case (sel)
				0: if (v >= MIN_PDU_SIZE && v <= MAX_PDU_SIZE) reg_model[0] = v;
				1: reg_model[1] = v & 32'h0000_0703;
				default: if (v <= MAX_SLAVE_ADDR) reg_model[2] = v;
			endcase
			check_registers();
		end
	endtask

	task automatic pdu_test();
		cs_data_t d;
		for (int w = 0; w < 64; w++) begin
			pdu_model[w] = next_random();
			write_pdu(pdu_word_addr_t'(w), pdu_model[w]);
		end
		for (int w = 0; w < 64; w++) begin
			read_pdu(pdu_word_addr_t'(w), d);
			check_value($sformatf("pdu_rdd[%0d]", w), d, pdu_model[w]);
		end
	endtask

	// gap is the expected negedge count from the previous sample to the start bit
	task automatic receive_byte(input byte_t exp_byte, input int idx, input int gap,
	                            input int div, input logic pen, input logic podd,
	                            input logic two);
		int    n;
		byte_t data;
		wait_for(SEL_TXD, 1'b0, 4 * div + 16, "a start bit", n);
		check_value("start bit delay", n, gap);
		check_value("oe during byte", oe, 1);
		skip_cycles(div / 2);
		check_value("start bit", txd, 0);
		for (int i = 0; i < 8; i++) begin
			skip_cycles(div);
			data[i] = txd;
		end
		if (pen) begin
			skip_cycles(div);
			check_value("parity bit", txd, (^data) ^ podd);
		end
		skip_cycles(div);
		check_value("stop bit", txd, 1);
		if (two) begin
			skip_cycles(div);
			check_value("second stop bit", txd, 1);
		end
		check_value($sformatf("frame byte %0d", idx), data, exp_byte);
	endtask

	task automatic send_frame();
		logic [31:0] r;
		byte_t       addr;
		int          size;
		int          div;
		int          n;
		int          c0;
		crc_t        crc;
		cs_data_t    cfg_word;
		cs_data_t    d;
		r        = next_random();
		addr     = byte_t'(next_random() % 248);
		size     = int'(next_random() % 253) + 1;
		div      = int'(BAUD_DIV_TABLE[r[1:0]]);
		cfg_word = cs_data_t'({r[4], r[3], r[2], 6'd0, r[1:0]});
		write_reg(REG_CONFIG, cfg_word);
		write_reg(REG_PDU_SIZE, cs_data_t'(size));
		write_reg(REG_SLAVE_ADDR, cs_data_t'(addr));
		reg_model[0] = cs_data_t'(size);
		reg_model[1] = cfg_word;
		reg_model[2] = cs_data_t'(addr);
		for (int w = 0; w <= (size - 1) / 4; w++) begin
			pdu_model[w] = next_random();
			write_pdu(pdu_word_addr_t'(w), pdu_model[w]);
		end
		frame_q.delete();
		frame_q.push_back(addr);
		for (int k = 0; k < size; k++)
			frame_q.push_back(pdu_model[k / 4][8 * (k % 4) +: 8]);
		crc = CRC_INIT;
		foreach (frame_q[i])
			crc = crc_add_byte(crc, frame_q[i]);
		frame_q.push_back(crc[7:0]);  // low byte goes first
		frame_q.push_back(crc[15:8]);

		write_reg(REG_CONTROL, next_random());
		check_value("ready after start", ready, 0);
		check_value("oe after start", oe, 1);
		for (int i = 0; i < frame_q.size(); i++)
			receive_byte(frame_q[i], i, (i == 0) ? DE_DELAY + 1 : div / 2, div,
			             r[2], r[3], r[4]);
		wait_for(SEL_OE, 1'b0, 2 * div, "oe release", n);
		check_value("oe release delay", n, div / 2);
		c0 = cycle_count;

		// all of these land in the silent interval and must be dropped
		write_reg(REG_PDU_SIZE, (reg_model[0] % MAX_PDU_SIZE) + 1);
		write_reg(REG_SLAVE_ADDR, (reg_model[2] + 1) % (MAX_SLAVE_ADDR + 1));
		write_reg(REG_CONFIG, reg_model[1] ^ 32'h0000_0703);
		write_pdu('0, ~pdu_model[0]);
		write_reg(REG_CONTROL, 32'd1);
		read_reg(REG_CONTROL, d);
		check_value("cs_rdd status while busy", d, 32'd0);
		wait_for(SEL_READY, 1'b1, T35_BITS * div + 16, "ready after silence", n);
		check_value("silent interval", cycle_count - c0, T35_BITS * div);

		for (int i = 0; i < 4 * DE_DELAY; i++) begin
			@(negedge clk);
			check_value("txd after frame", txd, 1);
			check_value("oe after frame", oe, 0);
			check_value("ready after frame", ready, 1);
		end
		check_registers();
		read_pdu('0, d);
		check_value("pdu_rdd[0] after busy write", d, pdu_model[0]);
	endtask

	initial begin
		reset    = 1'b1;
		cs_addr  = '0;
		cs_wr    = 1'b0;
		cs_wrd   = '0;
		pdu_addr = '0;
		pdu_wr   = 1'b0;
		pdu_wrd  = '0;
		reg_model[0] = 32'd1;
		reg_model[1] = 32'h0000_0101;  // baud code 1 with even parity
		reg_model[2] = 32'd1;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		check_value("ready after reset", ready, 1);
		check_value("oe after reset", oe, 0);
		check_value("txd after reset", txd, 1);
		check_registers();
		register_test();
		pdu_test();
		for (int f = 0; f < 5; f++)
			send_frame();
		if (i_dut.u_chk.fail_count == 0) begin
			$display("test passed");
			$finish;
		end else begin
			stop_with_failure("bound assertions on the line outputs failed");
		end
	end

endmodule

//--- source/crc16_engine.sv
/*
	Modbus CRC-16
	Running CRC over the frame bytes as they go out.
	One byte is folded in per absorb, all eight bit steps at once.
*/

`timescale 1ns/1ps

module crc16_engine (
	input  logic              clk,
	input  logic              reset,
	input  logic              clear,
	input  logic              absorb,
	input  modbus_pkg::byte_t data,
	output modbus_pkg::crc_t  crc
);
	import modbus_pkg::*;

	function automatic crc_t crc_step(input crc_t c, input byte_t d);
		crc_t r;
		r = c ^ {8'h00, d};
		for (int b = 0; b < 8; b++) begin
			if (r[0])
				r = (r >> 1) ^ CRC_POLY;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (reset)
			crc <= CRC_INIT;
		else if (clear)
			crc <= CRC_INIT;  // new frame
		else if (absorb)
			crc <= crc_step(crc, data);
	end

endmodule

//--- source/frame_sequencer.sv
/*
	Frame sequencer
	Master FSM for one request: driver enable and settling,
	address, PDU bytes and CRC to the transmitter, wait for the
	line to drain, then the 3.5-character silence before ready.
*/

`timescale 1ns/1ps

module frame_sequencer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start,
	input  modbus_pkg::frame_cfg_t frame_cfg,
	input  uart_pkg::baud_code_t   baud_code,
	input  modbus_pkg::byte_t      pdu_byte,
	input  logic                   tx_ready,
	input  modbus_pkg::crc_t       crc,
	output modbus_pkg::pdu_size_t  byte_index,
	output uart_pkg::tx_byte_t     tx,
	output logic                   crc_clear,
	output logic                   crc_absorb,
	output logic                   oe,
	output logic                   ready
);
	import modbus_pkg::*;
	import uart_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		DE_WAIT,
		SEND_ADDR,
		SEND_PDU,
		SEND_CRC_LO,
		SEND_CRC_HI,
		DRAIN,
		SILENCE
	} state_t;

	state_t         state_q;
	silence_count_t timer_q;       // settling and silence
	pdu_size_t      idx_q;
	logic           xfer;
	silence_count_t silence_last;

	// address goes out on the last settling cycle
	localparam silence_count_t DE_LAST = silence_count_t'(DE_DELAY - 2);

	assign silence_last = silence_count_t'(T35_BITS) *
	                      silence_count_t'(BAUD_DIV_TABLE[baud_code]) - silence_count_t'(1);

	always_comb begin
		tx.valid = 1'b0;
		tx.data  = pdu_byte;
		case (state_q)
			SEND_ADDR: begin
				tx.valid = 1'b1;
				tx.data  = frame_cfg.slave_addr;
			end
			SEND_PDU:  tx.valid = 1'b1;
			SEND_CRC_LO: begin
				tx.valid = 1'b1;
				tx.data  = crc[7:0];  // low byte first
			end
			SEND_CRC_HI: begin
				tx.valid = 1'b1;
				tx.data  = crc[15:8];
			end
			default: ;
		endcase
	end

	assign xfer       = tx.valid && tx_ready;
	assign crc_absorb = xfer && (state_q == SEND_ADDR || state_q == SEND_PDU);
	assign crc_clear  = start && (state_q == IDLE);
	assign byte_index = idx_q;
	assign ready      = state_q == IDLE;
	assign oe         = (state_q != IDLE) && (state_q != SILENCE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			timer_q <= '0;
			idx_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start) begin
						state_q <= DE_WAIT;
						timer_q <= '0;
						idx_q   <= '0;
					end
				end
				DE_WAIT: begin
					if (timer_q == DE_LAST)
						state_q <= SEND_ADDR;
					else
						timer_q <= timer_q + 1'b1;
				end
				SEND_ADDR: if (xfer) state_q <= SEND_PDU;
				SEND_PDU: begin
					if (xfer) begin
						if (idx_q == pdu_size_t'(frame_cfg.pdu_size - 8'd1))
							state_q <= SEND_CRC_LO;
						else
							idx_q <= idx_q + 8'd1;
					end
				end
				SEND_CRC_LO: if (xfer) state_q <= SEND_CRC_HI;
				SEND_CRC_HI: if (xfer) state_q <= DRAIN;
				DRAIN: begin
					if (tx_ready) begin  // last stop bit ends this cycle
						state_q <= SILENCE;
						timer_q <= '0;
					end
				end
				default: begin
					if (timer_q == silence_last)
						state_q <= IDLE;
					else
						timer_q <= timer_q + 1'b1;
				end
			endcase
		end
	end

endmodule

//--- source/modbus_pkg.sv
/*
	Modbus RTU frame definitions
	Frame-side widths, protocol limits, register map,
	CRC-16 constants and the structs passed between blocks
*/

package modbus_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  pdu_size_t;
	typedef logic [5:0]  pdu_word_addr_t;
	typedef logic [1:0]  cs_addr_t;
	typedef logic [31:0] cs_data_t;
	typedef logic [15:0] crc_t;

	localparam int MIN_PDU_SIZE   = 1;
	localparam int MAX_PDU_SIZE   = 253;
	localparam int MAX_SLAVE_ADDR = 247;     // 0 is broadcast

	localparam pdu_size_t PDU_SIZE_DEFAULT   = 8'd1;
	localparam byte_t     SLAVE_ADDR_DEFAULT = 8'd1;

	localparam cs_addr_t REG_PDU_SIZE   = 2'd0;
	localparam cs_addr_t REG_CONFIG     = 2'd1;
	localparam cs_addr_t REG_SLAVE_ADDR = 2'd2;
	localparam cs_addr_t REG_CONTROL    = 2'd3;

	localparam crc_t CRC_INIT = 16'hFFFF;
	localparam crc_t CRC_POLY = 16'hA001;  // reflected 0x8005

	localparam int DE_DELAY = 4;           // clocks of driver settling

	typedef struct packed {
		byte_t     slave_addr;
		pdu_size_t pdu_size;
	} frame_cfg_t;

	typedef struct packed {
		logic           wr;
		pdu_word_addr_t addr;
		cs_data_t       data;
	} pdu_write_t;

endpackage

//--- source/modbus_rtu_master.sv
/*
	Modbus RTU master, transmit side
	Register and PDU ports for software, frame sequencing,
	running CRC and the UART line with its driver enable
*/

`timescale 1ns/1ps

module modbus_rtu_master (
	input  logic                       clk,
	input  logic                       reset,
	input  modbus_pkg::cs_addr_t       cs_addr,
	input  logic                       cs_wr,
	input  modbus_pkg::cs_data_t       cs_wrd,
	output modbus_pkg::cs_data_t       cs_rdd,
	input  modbus_pkg::pdu_word_addr_t pdu_addr,
	input  logic                       pdu_wr,
	input  modbus_pkg::cs_data_t       pdu_wrd,
	output modbus_pkg::cs_data_t       pdu_rdd,
	output logic                       ready,
	output logic                       txd,
	output logic                       oe
);
	import modbus_pkg::*;
	import uart_pkg::*;

	frame_cfg_t frame_cfg;
	line_cfg_t  line_cfg;
	pdu_write_t pdu_write;
	pdu_size_t  byte_index;
	byte_t      pdu_byte;
	tx_byte_t   tx;
	crc_t       crc;
	logic       start;
	logic       tx_ready;
	logic       crc_clear;
	logic       crc_absorb;

	assign pdu_write = '{wr: pdu_wr && ready, addr: pdu_addr, data: pdu_wrd};  // locked while busy

	rtu_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.cs_addr   (cs_addr),
		.cs_wr     (cs_wr),
		.cs_wrd    (cs_wrd),
		.ready     (ready),
		.cs_rdd    (cs_rdd),
		.frame_cfg (frame_cfg),
		.line_cfg  (line_cfg),
		.start     (start)
	);

	pdu_buffer u_buffer (
		.clk        (clk),
		.reset      (reset),
		.wr         (pdu_write),
		.rd_word    (pdu_addr),
		.byte_index (byte_index),
		.rd_data    (pdu_rdd),
		.byte_out   (pdu_byte)
	);

	crc16_engine u_crc (
		.clk    (clk),
		.reset  (reset),
		.clear  (crc_clear),
		.absorb (crc_absorb),
		.data   (tx.data),
		.crc    (crc)
	);

	uart_tx u_tx (
		.clk      (clk),
		.reset    (reset),
		.cfg      (line_cfg),
		.tx       (tx),
		.tx_ready (tx_ready),
		.txd      (txd)
	);

	frame_sequencer u_seq (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.frame_cfg  (frame_cfg),
		.baud_code  (line_cfg.baud_code),
		.pdu_byte   (pdu_byte),
		.tx_ready   (tx_ready),
		.crc        (crc),
		.byte_index (byte_index),
		.tx         (tx),
		.crc_clear  (crc_clear),
		.crc_absorb (crc_absorb),
		.oe         (oe),
		.ready      (ready)
	);

endmodule

//--- source/pdu_buffer.sv
/*
	PDU buffer
	256 bytes written a word at a time from the PDU port.
	One word is read back for software, one byte for the sequencer.
*/

`timescale 1ns/1ps

module pdu_buffer (
	input  logic                       clk,
	input  logic                       reset,
	input  modbus_pkg::pdu_write_t     wr,
	input  modbus_pkg::pdu_word_addr_t rd_word,
	input  modbus_pkg::pdu_size_t      byte_index,
	output modbus_pkg::cs_data_t       rd_data,
	output modbus_pkg::byte_t          byte_out
);
	import modbus_pkg::*;

	byte_t mem [256];

	// first byte of a word sits in bits 7:0
	always_ff @(posedge clk) begin
		if (wr.wr && !reset) begin
			for (int i = 0; i < 4; i++) begin
				mem[{wr.addr, 2'(i)}] <= wr.data[8*i +: 8];
			end
		end
	end

	assign rd_data = {
		mem[{rd_word, 2'd3}],
		mem[{rd_word, 2'd2}],
		mem[{rd_word, 2'd1}],
		mem[{rd_word, 2'd0}]
	};

	assign byte_out = mem[byte_index];  // pdu byte k at index k

endmodule

//--- source/rtu_regs.sv
/*
	Control and status registers
	PDU size, line configuration and slave address with range
	checks, the start command and the combinational read mux.
	Writes are only taken while the master is ready.
*/

`timescale 1ns/1ps

module rtu_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  modbus_pkg::cs_addr_t   cs_addr,
	input  logic                   cs_wr,
	input  modbus_pkg::cs_data_t   cs_wrd,
	input  logic                   ready,
	output modbus_pkg::cs_data_t   cs_rdd,
	output modbus_pkg::frame_cfg_t frame_cfg,
	output uart_pkg::line_cfg_t    line_cfg,
	output logic                   start
);
	import modbus_pkg::*;
	import uart_pkg::*;

	logic wr_ok;
	logic size_ok;
	logic addr_ok;

	assign wr_ok   = cs_wr && ready;
	assign size_ok = (cs_wrd >= cs_data_t'(MIN_PDU_SIZE)) &&
	                 (cs_wrd <= cs_data_t'(MAX_PDU_SIZE));
	assign addr_ok = cs_wrd <= cs_data_t'(MAX_SLAVE_ADDR);  // broadcast allowed

	assign start = wr_ok && (cs_addr == REG_CONTROL);

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_cfg.pdu_size   <= PDU_SIZE_DEFAULT;
			frame_cfg.slave_addr <= SLAVE_ADDR_DEFAULT;
			line_cfg             <= LINE_CFG_DEFAULT;
		end else if (wr_ok) begin
			case (cs_addr)
				REG_PDU_SIZE: begin
					if (size_ok)
						frame_cfg.pdu_size <= cs_wrd[7:0];
				end
				REG_CONFIG: begin
					line_cfg.baud_code  <= cs_wrd[1:0];
					line_cfg.parity_en  <= cs_wrd[8];
					line_cfg.parity_odd <= cs_wrd[9];
					line_cfg.two_stop   <= cs_wrd[10];
				end
				REG_SLAVE_ADDR: begin
					if (addr_ok)
						frame_cfg.slave_addr <= cs_wrd[7:0];
				end
				default: ;  // control write only makes start
			endcase
		end
	end

	always_comb begin
		cs_rdd = '0;
		case (cs_addr)
			REG_PDU_SIZE:   cs_rdd[7:0] = frame_cfg.pdu_size;
			REG_CONFIG: begin
				cs_rdd[1:0]  = line_cfg.baud_code;
				cs_rdd[10:8] = {line_cfg.two_stop, line_cfg.parity_odd, line_cfg.parity_en};
			end
			REG_SLAVE_ADDR: cs_rdd[7:0] = frame_cfg.slave_addr;
			default:        cs_rdd[0]   = ready;  // status
		endcase
	end

endmodule

//--- source/uart_pkg.sv
/*
	Serial line definitions
	Divisor table, silent interval length and the
	line configuration shared by registers and transmitter
*/

package uart_pkg;

	typedef logic [1:0]  baud_code_t;
	typedef logic [7:0]  baud_div_t;
	typedef logic [13:0] silence_count_t;

	// clocks per bit with code 0 the slowest rate
	localparam baud_div_t [3:0] BAUD_DIV_TABLE = {8'd8, 8'd16, 8'd32, 8'd64};

	localparam baud_code_t BAUD_CODE_DEFAULT = 2'd1;

	localparam int T35_BITS = 42;          // 3.5 chars of 12 bits

	typedef struct packed {
		baud_code_t baud_code;
		logic       parity_en;
		logic       parity_odd;
		logic       two_stop;
	} line_cfg_t;

	localparam line_cfg_t LINE_CFG_DEFAULT = '{
		baud_code:  BAUD_CODE_DEFAULT,
		parity_en:  1'b1,
		parity_odd: 1'b0,
		two_stop:   1'b0
	};

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} tx_byte_t;

endpackage

//--- source/uart_tx.sv
/*
	UART transmitter
	Start bit, 8 data bits LSB first, optional even/odd parity
	and one or two stop bits, each held for the selected divisor.
	The last stop cycle is spent idle so a new byte follows at once.
*/

`timescale 1ns/1ps

module uart_tx (
	input  logic                clk,
	input  logic                reset,
	input  uart_pkg::line_cfg_t cfg,
	input  uart_pkg::tx_byte_t  tx,
	output logic                tx_ready,
	output logic                txd
);
	import uart_pkg::*;

	baud_div_t   div_q;          // divisor for the byte in flight
	baud_div_t   baud_cnt_q;
	logic [11:0] shift_q;        // bits still to send with lsb next
	logic [3:0]  bits_left_q;
	logic        busy_q;
	logic        parity;
	logic [3:0]  frame_bits;
	logic [11:0] frame_word;

	assign tx_ready   = !busy_q;
	assign parity     = (^tx.data) ^ cfg.parity_odd;
	assign frame_bits = 4'd10 + {3'd0, cfg.parity_en} + {3'd0, cfg.two_stop};

	always_comb begin
		if (cfg.parity_en)
			frame_word = {2'b11, parity, tx.data, 1'b0};
		else
			frame_word = {3'b111, tx.data, 1'b0};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q      <= 1'b0;
			txd         <= 1'b1;
			bits_left_q <= '0;
			baud_cnt_q  <= '0;
		end else if (!busy_q) begin
			if (tx.valid) begin
				busy_q      <= 1'b1;
				txd         <= 1'b0;  // start bit
				shift_q     <= {1'b1, frame_word[11:1]};
				bits_left_q <= frame_bits - 4'd1;
				div_q       <= BAUD_DIV_TABLE[cfg.baud_code];
				baud_cnt_q  <= BAUD_DIV_TABLE[cfg.baud_code] - 8'd1;
			end
		end else if (bits_left_q == 4'd0 && baud_cnt_q == 8'd1) begin
			busy_q <= 1'b0;  // final stop cycle runs idle
		end else if (baud_cnt_q == 8'd0) begin
			txd         <= shift_q[0];
			shift_q     <= {1'b1, shift_q[11:1]};
			bits_left_q <= bits_left_q - 4'd1;
			baud_cnt_q  <= div_q - 8'd1;
		end else begin
			baud_cnt_q <= baud_cnt_q - 8'd1;
		end
	end

endmodule
